// File: tb/vtx_store_testdata.txt
# op id level flag expect, every field in hex
# op 0 root, 1 read, 2 push, 3 pull, 4 set iteration, 5 iteration end, 6 idle for level cycles
0 05 00 0 00
1 05 00 0 00
1 10 00 0 ff
1 ff 00 0 ff
2 10 03 0 01
6 00 05 0 00
1 10 00 0 03
2 10 02 1 01
6 00 05 0 00
2 10 02 0 00
6 00 05 0 00
2 10 07 0 00
6 00 05 0 00
1 10 00 0 02
4 00 03 0 00
3 20 02 1 01
3 21 04 0 00
3 22 ff 1 00
1 20 00 0 03
1 21 00 0 ff
6 00 05 0 00
5 00 00 0 01
2 30 04 0 01
5 00 00 0 00
6 00 06 0 00
2 40 01 0 01
2 41 02 1 01
2 42 03 0 01
6 00 05 0 00
1 40 00 0 01
1 41 00 0 02
1 42 00 0 03

// File: src.f
design/bfs_pkg.sv
design/vtx_ram.sv
design/push_pending_fifo.sv
design/vtx_update_ctrl.sv
design/vtx_store_top.sv
tb/vtx_store_tb.sv

// File: tb/vtx_store_tb.sv
`timescale 1ns/1ps

module vtx_store_tb;

    localparam int clk_period   = 4;
    localparam int read_latency = 4; // Request edge to rd_value_valid
    localparam int push_latency = 4;
    localparam int pull_latency = 1;
    localparam int iter_latency = 1;

    logic                                clk;
    logic                                rst;
    logic                                rd_valid;
    logic [bfs_pkg::v_id_width-1:0]      rd_id;
    logic                                wr_valid;
    logic                                wr_push;
    logic [bfs_pkg::v_id_width-1:0]      wr_id;
    logic [bfs_pkg::v_value_width-1:0]   wr_value;
    logic                                wr_pull_first;
    logic                                front_iteration_end;
    logic [bfs_pkg::iteration_width-1:0] front_iteration_id;
    logic [bfs_pkg::v_id_width-1:0]      root_id;
    logic [bfs_pkg::v_value_width-1:0]   rd_value;
    logic                                rd_value_valid;
    logic [bfs_pkg::v_id_width-1:0]      active_id;
    logic                                active_updated;
    logic                                active_pull_first;
    logic                                active_valid;
    logic                                iteration_end;

    // Operations as read from the data file
    int                                op_code   [$];
    logic [bfs_pkg::v_id_width-1:0]    op_id     [$];
    logic [bfs_pkg::v_value_width-1:0] op_level  [$];
    logic                              op_flag   [$];
    logic [bfs_pkg::v_value_width-1:0] op_expect [$];

    // Outstanding responses, each with the edge count at which it must be visible
    int                                rd_due [$];
    logic [bfs_pkg::v_value_width-1:0] rd_exp [$];
    int                                act_due [$];
    logic [bfs_pkg::v_id_width-1:0]    act_id_exp [$];
    logic                              act_upd_exp [$];
    logic                              act_pf_exp [$];
    int                                ie_due [$];
    logic                              ie_exp [$];

    logic [bfs_pkg::v_value_width-1:0] shadow [bfs_pkg::vtx_count];
    int                                edge_count = 0;
    int                                last_issue = -100; // Sample edge of the newest read or push

    vtx_store_top u_vtx_store_top (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) edge_count <= edge_count + 1;

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [bfs_pkg::v_value_width-1:0] expected,
                               input logic [bfs_pkg::v_value_width-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%h got 0x%h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_id(input string name, input logic [bfs_pkg::v_id_width-1:0] expected,
                            input logic [bfs_pkg::v_id_width-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%h got 0x%h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%h got 0x%h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic load_ops();
        int    fd;
        int    n;
        int    c;
        int    i;
        int    l;
        int    f;
        int    e;
        string line;
        fd = $fopen("tb/vtx_store_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file tb/vtx_store_testdata.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h %h", c, i, l, f, e) == 5) begin
                    op_code.push_back(c);
                    op_id.push_back(i);
                    op_level.push_back(l);
                    op_flag.push_back(f[0]);
                    op_expect.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    // Starts a new input cycle with every strobe low
    task automatic next_slot();
        @(posedge clk);
        #1;
        rd_valid            = 1'b0;
        wr_valid            = 1'b0;
        wr_push             = 1'b0;
        front_iteration_end = 1'b0;
    endtask

    // Pulls level 0 into the reserved ID so that the RAM holds a real level there
    task automatic store_at_reserved_id();
        next_slot();
        wr_valid      = 1'b1;
        wr_push       = 1'b0;
        wr_id         = bfs_pkg::reserved_v_id;
        wr_value      = '0;
        wr_pull_first = 1'b0;
        act_due.push_back(edge_count + pull_latency);
        act_id_exp.push_back(bfs_pkg::reserved_v_id);
        act_upd_exp.push_back(1'b1); // Level 0 is valid and never above the iteration
        act_pf_exp.push_back(1'b0);
        shadow[bfs_pkg::reserved_v_id] = 1;
    endtask

    task automatic run_op(input int k);
        logic [bfs_pkg::v_value_width-1:0] stored;
        logic [bfs_pkg::v_value_width-1:0] model;
        if (op_code[k] == 6) begin
            repeat (op_level[k]) next_slot();
            return;
        end
        if (op_code[k] == 1 && op_id[k] == bfs_pkg::reserved_v_id) begin
            store_at_reserved_id();
        end
        next_slot();
        stored = shadow[op_id[k]];
        case (op_code[k])
            1: model = (op_id[k] == bfs_pkg::reserved_v_id) ? bfs_pkg::invalid_value : stored;
            2: model = (op_level[k] < stored) || (stored == bfs_pkg::invalid_value);
            3: model = (op_level[k] != bfs_pkg::invalid_value) && (op_level[k] <= front_iteration_id);
            5: model = (edge_count + 1 - last_issue) >= read_latency;
            default: model = op_expect[k];
        endcase
        if (model !== op_expect[k]) begin
            $display("test data line %0d expects 0x%h but the reference model gives 0x%h",
                     k, op_expect[k], model);
            stop_with_failure();
        end
        case (op_code[k])
            1: begin
                rd_valid = 1'b1;
                rd_id    = op_id[k];
                rd_due.push_back(edge_count + read_latency);
                rd_exp.push_back(model);
                last_issue = edge_count + 1;
            end
            2, 3: begin
                wr_valid      = 1'b1;
                wr_push       = (op_code[k] == 2);
                wr_id         = op_id[k];
                wr_value      = op_level[k];
                wr_pull_first = op_flag[k];
                act_due.push_back(edge_count + ((op_code[k] == 2) ? push_latency : pull_latency));
                act_id_exp.push_back(op_id[k]);
                act_upd_exp.push_back(model[0]);
                act_pf_exp.push_back(op_flag[k]);
                if (op_code[k] == 2) last_issue = edge_count + 1;
                if (model[0]) begin
                    shadow[op_id[k]] = (op_code[k] == 2) ? op_level[k] : op_level[k] + 1'b1;
                end
            end
            4: front_iteration_id = op_level[k];
            5: begin
                front_iteration_end = 1'b1;
                ie_due.push_back(edge_count + iter_latency);
                ie_exp.push_back(model[0]);
            end
            default: begin
                $display("unknown opcode %0d on test data line %0d", op_code[k], k);
                stop_with_failure();
            end
        endcase
    endtask

    task automatic check_outputs();
        logic exp_rd;
        logic exp_act;
        logic exp_ie;
        exp_rd  = rd_due.size() > 0 && rd_due[0] == edge_count;
        exp_act = act_due.size() > 0 && act_due[0] == edge_count;
        exp_ie  = ie_due.size() > 0 && ie_due[0] == edge_count;
        check_bit("rd_value_valid", exp_rd, rd_value_valid);
        if (exp_rd) begin
            check_value("rd_value", rd_exp[0], rd_value);
            void'(rd_due.pop_front());
            void'(rd_exp.pop_front());
        end
        check_bit("active_valid", exp_act, active_valid);
        if (exp_act) begin
            check_id("active_id", act_id_exp[0], active_id);
            check_bit("active_updated", act_upd_exp[0], active_updated);
            check_bit("active_pull_first", act_pf_exp[0], active_pull_first);
            void'(act_due.pop_front());
            void'(act_id_exp.pop_front());
            void'(act_upd_exp.pop_front());
            void'(act_pf_exp.pop_front());
        end else begin
            check_bit("active_updated", 1'b0, active_updated);
        end
        check_bit("iteration_end", exp_ie && ie_exp[0], iteration_end);
        if (exp_ie) begin
            void'(ie_due.pop_front());
            void'(ie_exp.pop_front());
        end
    endtask

    // Outputs are compared at the falling edge, half a cycle after they change
    always @(negedge clk) begin
        if (!rst) check_outputs();
    end

    initial begin
        rst                 = 1'b1;
        rd_valid            = 1'b0;
        rd_id               = '0;
        wr_valid            = 1'b0;
        wr_push             = 1'b0;
        wr_id               = '0;
        wr_value            = '0;
        wr_pull_first       = 1'b0;
        front_iteration_end = 1'b0;
        front_iteration_id  = '0;
        root_id             = '0;
        load_ops();
        if (op_code.size() == 0 || op_code[0] != 0) begin
            $display("the test data must start with a root line");
            stop_with_failure();
        end
        root_id = op_id[0];
        for (int v = 0; v < bfs_pkg::vtx_count; v++) shadow[v] = bfs_pkg::invalid_value;
        shadow[root_id] = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int k = 1; k < op_code.size(); k++) run_op(k);
        next_slot();
        wait (rd_due.size() == 0 && act_due.size() == 0 && ie_due.size() == 0);
        repeat (3) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        @(negedge rst);
        #((op_code.size() * 10 + 100) * clk_period);
        $display("timeout: outputs never arrived");
        stop_with_failure();
    end

endmodule

// File: design/vtx_store_top.sv
`timescale 1ns/1ps

module vtx_store_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rd_valid,
    input  logic [bfs_pkg::v_id_width-1:0]      rd_id,
    input  logic                                wr_valid,
    input  logic                                wr_push,
    input  logic [bfs_pkg::v_id_width-1:0]      wr_id,
    input  logic [bfs_pkg::v_value_width-1:0]   wr_value,
    input  logic                                wr_pull_first,
    input  logic                                front_iteration_end,
    input  logic [bfs_pkg::iteration_width-1:0] front_iteration_id,
    input  logic [bfs_pkg::v_id_width-1:0]      root_id,
    output logic [bfs_pkg::v_value_width-1:0]   rd_value,
    output logic                                rd_value_valid,
    output logic [bfs_pkg::v_id_width-1:0]      active_id,
    output logic                                active_updated,
    output logic                                active_pull_first,
    output logic                                active_valid,
    output logic                                iteration_end
);

    logic [bfs_pkg::v_id_width-1:0]    ram_rd_addr;
    logic                              ram_we;
    logic [bfs_pkg::v_id_width-1:0]    ram_wr_addr;
    logic [bfs_pkg::v_value_width-1:0] ram_wr_data;
    logic [bfs_pkg::v_value_width-1:0] ram_rd_data;

    logic                              fifo_push;
    logic                              fifo_pop;
    logic [bfs_pkg::v_id_width-1:0]    fifo_in_id;
    logic [bfs_pkg::v_value_width-1:0] fifo_in_value;
    logic                              fifo_in_push;
    logic                              fifo_in_pull_first;
    logic [bfs_pkg::v_id_width-1:0]    fifo_out_id;
    logic [bfs_pkg::v_value_width-1:0] fifo_out_value;
    logic                              fifo_out_push;
    logic                              fifo_out_pull_first;
    logic                              fifo_empty;

    vtx_update_ctrl u_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .rd_valid            (rd_valid),
        .rd_id               (rd_id),
        .wr_valid            (wr_valid),
        .wr_push             (wr_push),
        .wr_id               (wr_id),
        .wr_value            (wr_value),
        .wr_pull_first       (wr_pull_first),
        .front_iteration_end (front_iteration_end),
        .front_iteration_id  (front_iteration_id),
        .root_id             (root_id),
        .ram_rd_addr         (ram_rd_addr),
        .ram_we              (ram_we),
        .ram_wr_addr         (ram_wr_addr),
        .ram_wr_data         (ram_wr_data),
        .ram_rd_data         (ram_rd_data),
        .fifo_push           (fifo_push),
        .fifo_pop            (fifo_pop),
        .fifo_in_id          (fifo_in_id),
        .fifo_in_value       (fifo_in_value),
        .fifo_in_push        (fifo_in_push),
        .fifo_in_pull_first  (fifo_in_pull_first),
        .fifo_out_id         (fifo_out_id),
        .fifo_out_value      (fifo_out_value),
        .fifo_out_push       (fifo_out_push),
        .fifo_out_pull_first (fifo_out_pull_first),
        .fifo_empty          (fifo_empty),
        .rd_value            (rd_value),
        .rd_value_valid      (rd_value_valid),
        .active_id           (active_id),
        .active_updated      (active_updated),
        .active_pull_first   (active_pull_first),
        .active_valid        (active_valid),
        .iteration_end       (iteration_end)
    );

    vtx_ram u_ram (
        .clk     (clk),
        .we      (ram_we),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    push_pending_fifo u_fifo (
        .clk            (clk),
        .rst            (rst),
        .push           (fifo_push),
        .pop            (fifo_pop),
        .in_id          (fifo_in_id),
        .in_value       (fifo_in_value),
        .in_push        (fifo_in_push),
        .in_pull_first  (fifo_in_pull_first),
        .out_id         (fifo_out_id),
        .out_value      (fifo_out_value),
        .out_push       (fifo_out_push),
        .out_pull_first (fifo_out_pull_first),
        .empty          (fifo_empty)
    );

endmodule

// File: design/vtx_update_ctrl.sv
`timescale 1ns/1ps

module vtx_update_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rd_valid,
    input  logic [bfs_pkg::v_id_width-1:0]      rd_id,
    input  logic                                wr_valid,
    input  logic                                wr_push,
    input  logic [bfs_pkg::v_id_width-1:0]      wr_id,
    input  logic [bfs_pkg::v_value_width-1:0]   wr_value,
    input  logic                                wr_pull_first,
    input  logic                                front_iteration_end,
    input  logic [bfs_pkg::iteration_width-1:0] front_iteration_id,
    input  logic [bfs_pkg::v_id_width-1:0]      root_id,
    output logic [bfs_pkg::v_id_width-1:0]      ram_rd_addr,
    output logic                                ram_we,
    output logic [bfs_pkg::v_id_width-1:0]      ram_wr_addr,
    output logic [bfs_pkg::v_value_width-1:0]   ram_wr_data,
    input  logic [bfs_pkg::v_value_width-1:0]   ram_rd_data,
    output logic                                fifo_push,
    output logic                                fifo_pop,
    output logic [bfs_pkg::v_id_width-1:0]      fifo_in_id,
    output logic [bfs_pkg::v_value_width-1:0]   fifo_in_value,
    output logic                                fifo_in_push,
    output logic                                fifo_in_pull_first,
    input  logic [bfs_pkg::v_id_width-1:0]      fifo_out_id,
    input  logic [bfs_pkg::v_value_width-1:0]   fifo_out_value,
    input  logic                                fifo_out_push,
    input  logic                                fifo_out_pull_first,
    input  logic                                fifo_empty,
    output logic [bfs_pkg::v_value_width-1:0]   rd_value,
    output logic                                rd_value_valid,
    output logic [bfs_pkg::v_id_width-1:0]      active_id,
    output logic                                active_updated,
    output logic                                active_pull_first,
    output logic                                active_valid,
    output logic                                iteration_end
);

    logic                                     rd_issue;
    logic                                     rd_strobe;
    logic [bfs_pkg::ram_read_latency-1:0]     dv_sr;
    logic [bfs_pkg::ram_read_latency-1:0]     rsv_sr;
    logic                                     ret_valid;
    logic [bfs_pkg::v_value_width-1:0]        ret_data;
    logic                                     pull_valid;
    logic                                     pull_ok;
    logic                                     push_ret;
    logic                                     push_better;

    // A source read wins over a push arriving in the same cycle
    assign rd_issue = rd_valid || (wr_valid && wr_push);

    assign fifo_push          = rd_issue;
    assign fifo_in_id         = rd_valid ? rd_id : wr_id;
    assign fifo_in_value      = wr_value;
    assign fifo_in_push       = !rd_valid;
    assign fifo_in_pull_first = !rd_valid && wr_pull_first;

    always_ff @(posedge clk) begin
        ram_rd_addr <= rd_valid ? rd_id : wr_id;
        rsv_sr <= {rsv_sr[bfs_pkg::ram_read_latency-2:0], ram_rd_addr == bfs_pkg::reserved_v_id};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_strobe <= 1'b0;
            dv_sr     <= '0;
        end else begin
            rd_strobe <= rd_issue;
            dv_sr     <= {dv_sr[bfs_pkg::ram_read_latency-2:0], rd_strobe};
        end
    end

    assign ret_valid = dv_sr[bfs_pkg::ram_read_latency-1];
    assign ret_data  = rsv_sr[bfs_pkg::ram_read_latency-1] ? bfs_pkg::invalid_value : ram_rd_data;
    assign fifo_pop  = ret_valid; // Entries come back in issue order

    assign pull_valid = wr_valid && !wr_push;
    assign pull_ok    = (wr_value != bfs_pkg::invalid_value) && (wr_value <= front_iteration_id);

    assign push_ret    = ret_valid && fifo_out_push;
    assign push_better = (ret_data > fifo_out_value) || (ret_data == bfs_pkg::invalid_value);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Root vertex is seeded with level 0 for as long as reset is held
            ram_we         <= 1'b1;
            ram_wr_addr    <= root_id;
            ram_wr_data    <= '0;
            rd_value_valid <= 1'b0;
            active_valid   <= 1'b0;
            active_updated <= 1'b0;
            iteration_end  <= 1'b0;
        end else begin
            rd_value       <= ret_data;
            rd_value_valid <= ret_valid && !fifo_out_push;
            iteration_end  <= front_iteration_end && fifo_empty;

            if (pull_valid) begin // A completing push in this cycle is dropped
                ram_we            <= pull_ok;
                ram_wr_addr       <= wr_id;
                ram_wr_data       <= wr_value + 1'b1;
                active_id         <= wr_id;
                active_updated    <= pull_ok;
                active_pull_first <= wr_pull_first;
                active_valid      <= 1'b1;
            end else if (push_ret) begin
                ram_we            <= push_better;
                ram_wr_addr       <= fifo_out_id;
                ram_wr_data       <= fifo_out_value;
                active_id         <= fifo_out_id;
                active_updated    <= push_better;
                active_pull_first <= fifo_out_pull_first;
                active_valid      <= 1'b1;
            end else begin
                ram_we         <= 1'b0;
                active_updated <= 1'b0;
                active_valid   <= 1'b0;
            end
        end
    end

    // A pull in the cycle a push returns would lose that push report
    a_no_pull_on_push_return: assert property (
        @(posedge clk) disable iff (rst) push_ret |-> !pull_valid);

endmodule

// File: design/push_pending_fifo.sv
`timescale 1ns/1ps

module push_pending_fifo (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              push,
    input  logic                              pop,
    input  logic [bfs_pkg::v_id_width-1:0]    in_id,
    input  logic [bfs_pkg::v_value_width-1:0] in_value,
    input  logic                              in_push,
    input  logic                              in_pull_first,
    output logic [bfs_pkg::v_id_width-1:0]    out_id,
    output logic [bfs_pkg::v_value_width-1:0] out_value,
    output logic                              out_push,
    output logic                              out_pull_first,
    output logic                              empty
);

    logic [bfs_pkg::v_id_width-1:0]    id_mem    [bfs_pkg::fifo_depth];
    logic [bfs_pkg::v_value_width-1:0] value_mem [bfs_pkg::fifo_depth];
    logic [bfs_pkg::fifo_depth-1:0]    push_mem;
    logic [bfs_pkg::fifo_depth-1:0]    pf_mem;

    logic [bfs_pkg::fifo_depth_width-1:0] wr_ptr;
    logic [bfs_pkg::fifo_depth_width-1:0] rd_ptr;
    logic [bfs_pkg::fifo_depth_width:0]   count;
    logic                                 full;

    assign empty = (count == 0);
    assign full  = (count == bfs_pkg::fifo_depth);

    // Show-ahead, the head entry is visible without a pop
    assign out_id         = id_mem[rd_ptr];
    assign out_value      = value_mem[rd_ptr];
    assign out_push       = push_mem[rd_ptr];
    assign out_pull_first = pf_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            id_mem[wr_ptr]    <= in_id;
            value_mem[wr_ptr] <= in_value;
            push_mem[wr_ptr]  <= in_push;
            pf_mem[wr_ptr]    <= in_pull_first;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // No back-pressure exists upstream, so the in-flight limit must hold by construction
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// File: design/vtx_ram.sv
`timescale 1ns/1ps

module vtx_ram (
    input  logic                              clk,
    input  logic                              we,
    input  logic [bfs_pkg::v_id_width-1:0]    wr_addr,
    input  logic [bfs_pkg::v_value_width-1:0] wr_data,
    input  logic [bfs_pkg::v_id_width-1:0]    rd_addr,
    output logic [bfs_pkg::v_value_width-1:0] rd_data
);

    logic [bfs_pkg::v_value_width-1:0] mem [bfs_pkg::vtx_count];
    logic [bfs_pkg::v_id_width-1:0]    rd_addr_q;

    // Every vertex starts out unvisited
    initial begin
        for (int i = 0; i < bfs_pkg::vtx_count; i++) begin
            mem[i] = bfs_pkg::invalid_value;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Two-stage read, old data is returned on a same-address write
    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;
        rd_data   <= mem[rd_addr_q];
    end

endmodule

// File: design/bfs_pkg.sv
package bfs_pkg;

    // Vertex IDs address the vertex RAM directly
    localparam int v_id_width      = 8;
    localparam int v_value_width   = 8;
    localparam int iteration_width = 8;

    localparam int vtx_count = 1 << v_id_width;

    // All-ones level marks a vertex that has not been visited yet
    localparam logic [v_value_width-1:0] invalid_value = '1;

    // Never stored in the RAM, a read of it answers with invalid_value
    localparam logic [v_id_width-1:0] reserved_v_id = '1;

    // Pending FIFO holds every push or source read while its RAM read is in flight
    localparam int fifo_depth_width = 2;
    localparam int fifo_depth       = 1 << fifo_depth_width;

    // Address register plus output register inside the RAM
    localparam int ram_read_latency = 2;

endpackage
